// File: common/silver_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// widths fixed by the Silver ISA; dropped opcodes decode to opc_nop
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package silver_pkg;

   typedef logic [31:0] word_t;
   typedef logic [5:0]  reg_addr_t;
   typedef logic [5:0]  opc_t;
   typedef logic [3:0]  func_t;
   typedef logic [1:0]  res_sel_t;
   typedef logic [1:0]  fwd_sel_t;

   localparam opc_t opc_normal        = 6'd0;
   localparam opc_t opc_shift         = 6'd1;
   localparam opc_t opc_out           = 6'd6;
   localparam opc_t opc_jump          = 6'd9;
   localparam opc_t opc_jump_zero     = 6'd10;
   localparam opc_t opc_jump_not_zero = 6'd11;
   localparam opc_t opc_load_const    = 6'd13;
   localparam opc_t opc_load_upper    = 6'd14;
   localparam opc_t opc_nop           = 6'd15;

   localparam func_t fn_add      = 4'd0;
   localparam func_t fn_addc     = 4'd1;
   localparam func_t fn_sub      = 4'd2;
   localparam func_t fn_carry    = 4'd3;
   localparam func_t fn_overflow = 4'd4;
   localparam func_t fn_inc      = 4'd5;
   localparam func_t fn_dec      = 4'd6;
   localparam func_t fn_mul      = 4'd7;
   localparam func_t fn_mulhu    = 4'd8;
   localparam func_t fn_and      = 4'd9;
   localparam func_t fn_or       = 4'd10;
   localparam func_t fn_xor      = 4'd11;
   localparam func_t fn_equal    = 4'd12;
   localparam func_t fn_less     = 4'd13;
   localparam func_t fn_lower    = 4'd14;
   localparam func_t fn_snd      = 4'd15;

   localparam res_sel_t res_alu   = 2'd0;
   localparam res_sel_t res_shift = 2'd1;
   localparam res_sel_t res_link  = 2'd2; // pc + 4
   localparam res_sel_t res_const = 2'd3;

   localparam fwd_sel_t fwd_none = 2'd0;
   localparam fwd_sel_t fwd_mem  = 2'd1;
   localparam fwd_sel_t fwd_wb   = 2'd2;

   typedef struct packed {
      opc_t      opc;
      func_t     func;
      reg_addr_t ra;
      reg_addr_t rb;
      reg_addr_t rd;
      logic      a_imm;
      logic      b_imm;
      logic      w_imm;
      word_t     imm_a;
      word_t     imm_b;
      word_t     imm_w;
      word_t     const_val; // upper constant sits in bits 31:23
      res_sel_t  res_sel;
      logic      wr_reg;
      logic      is_out;
   } decoded_t;

   typedef struct packed {
      logic     valid;
      word_t    pc;
      decoded_t dec;
      word_t    a;
      word_t    b;
      word_t    w;
   } id_ex_t;

   typedef struct packed {
      logic      valid;
      reg_addr_t rd;
      logic      wr_reg;
      logic      is_out;
      word_t     result;
   } ex_wb_t;

endpackage

`default_nettype wire

// File: design/silver_decoder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// purely combinational; memory, In, interrupt and accelerator are nops
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module silver_decoder (
   input  wire silver_pkg::word_t instr,
   output silver_pkg::decoded_t   dec
);

   silver_pkg::opc_t raw_opc;
   silver_pkg::opc_t opc;

   assign raw_opc = instr[5:0];

   always_comb begin
      if (instr[24]) begin
         if (instr[31])
            opc = silver_pkg::opc_load_const;
         else if (instr[23:9] == 15'd0)
            opc = silver_pkg::opc_load_upper;
         else
            opc = silver_pkg::opc_nop;
      end else if (instr[31] && (raw_opc < 6'd10 || raw_opc > 6'd12)) begin
         opc = silver_pkg::opc_nop; // only conditional jumps take an immediate w
      end else begin
         case (raw_opc)
            silver_pkg::opc_normal, silver_pkg::opc_shift, silver_pkg::opc_out,
            silver_pkg::opc_jump, silver_pkg::opc_jump_zero,
            silver_pkg::opc_jump_not_zero: opc = raw_opc;
            default: opc = silver_pkg::opc_nop;
         endcase
      end
   end

   always_comb begin
      dec.opc   = opc;
      dec.func  = instr[9:6];
      dec.ra    = instr[22:17];
      dec.rb    = instr[15:10];
      dec.rd    = instr[30:25];
      dec.a_imm = instr[23];
      dec.b_imm = instr[16];
      dec.w_imm = instr[31];
      dec.imm_a = {{26{instr[22]}}, instr[22:17]};
      dec.imm_b = {{26{instr[15]}}, instr[15:10]};
      dec.imm_w = {{26{instr[30]}}, instr[30:25]};

      if (opc == silver_pkg::opc_load_upper)
         dec.const_val = {instr[8:0], 23'd0};
      else if (instr[23])
         dec.const_val = 32'd0 - {9'd0, instr[22:0]}; // negated constant
      else
         dec.const_val = {9'd0, instr[22:0]};

      case (opc)
         silver_pkg::opc_shift: dec.res_sel = silver_pkg::res_shift;
         silver_pkg::opc_jump:  dec.res_sel = silver_pkg::res_link;
         silver_pkg::opc_load_const,
         silver_pkg::opc_load_upper: dec.res_sel = silver_pkg::res_const;
         default: dec.res_sel = silver_pkg::res_alu;
      endcase

      dec.wr_reg = (opc == silver_pkg::opc_normal) || (opc == silver_pkg::opc_shift) ||
                   (opc == silver_pkg::opc_out) || (opc == silver_pkg::opc_jump) ||
                   (opc == silver_pkg::opc_load_const) || (opc == silver_pkg::opc_load_upper);
      dec.is_out = (opc == silver_pkg::opc_out);
   end

endmodule

`default_nettype wire

// File: design/silver_regfile.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reads are combinational and see a same-cycle writeback value
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module silver_regfile (
   input  wire logic                  clk,
   input  wire logic                  rst_n,
   input  wire silver_pkg::reg_addr_t ra,
   input  wire silver_pkg::reg_addr_t rb,
   input  wire silver_pkg::reg_addr_t rd,
   output silver_pkg::word_t          a,
   output silver_pkg::word_t          b,
   output silver_pkg::word_t          w,
   input  wire silver_pkg::ex_wb_t    wb
);

   silver_pkg::word_t regs [64];
   logic wr_en;

   assign wr_en = wb.valid && wb.wr_reg;

   // same-cycle write wins over the stored word
   assign a = (wr_en && wb.rd == ra) ? wb.result : regs[ra];
   assign b = (wr_en && wb.rd == rb) ? wb.result : regs[rb];
   assign w = (wr_en && wb.rd == rd) ? wb.result : regs[rd];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < 64; i++)
            regs[i] <= '0;
      end else if (wr_en) begin
         regs[wb.rd] <= wb.result;
      end
   end

   a_wr_addr_known: assert property (@(posedge clk) disable iff (!rst_n)
      wr_en |-> !$isunknown(wb.rd));

endmodule

`default_nettype wire

// File: design/silver_forward.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// no loads in the core, so mem and wb results are always final
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module silver_forward (
   input  wire silver_pkg::reg_addr_t ra,
   input  wire silver_pkg::reg_addr_t rb,
   input  wire silver_pkg::reg_addr_t rd,
   input  wire logic                  a_imm,
   input  wire logic                  b_imm,
   input  wire logic                  w_imm,
   input  wire silver_pkg::ex_wb_t    mem,
   input  wire silver_pkg::ex_wb_t    wb,
   output silver_pkg::fwd_sel_t       fwd_a,
   output silver_pkg::fwd_sel_t       fwd_b,
   output silver_pkg::fwd_sel_t       fwd_w
);

   // memory stage is younger, so it wins over writeback
   function automatic silver_pkg::fwd_sel_t choose(input silver_pkg::reg_addr_t addr,
                                                   input logic is_imm,
                                                   input silver_pkg::ex_wb_t mem_s,
                                                   input silver_pkg::ex_wb_t wb_s);
      if (is_imm)
         return silver_pkg::fwd_none;
      else if (mem_s.valid && mem_s.wr_reg && mem_s.rd == addr)
         return silver_pkg::fwd_mem;
      else if (wb_s.valid && wb_s.wr_reg && wb_s.rd == addr)
         return silver_pkg::fwd_wb;
      else
         return silver_pkg::fwd_none;
   endfunction

   assign fwd_a = choose(ra, a_imm, mem, wb);
   assign fwd_b = choose(rb, b_imm, mem, wb);
   assign fwd_w = choose(rd, w_imm, mem, wb);

endmodule

`default_nettype wire

// File: execute/silver_alu.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// result is combinational; carry and overflow flags load on update
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module silver_alu (
   input  wire logic              clk,
   input  wire logic              rst_n,
   input  wire silver_pkg::func_t func,
   input  wire silver_pkg::word_t x,
   input  wire silver_pkg::word_t y,
   input  wire logic              update,
   output silver_pkg::word_t      res
);

   logic carry_q;
   logic ovf_q;
   logic [32:0] sum;
   silver_pkg::word_t diff;
   logic [63:0] prod;
   logic add_ovf;
   logic sub_ovf;

   assign sum  = {1'b0, x} + {1'b0, y} +
                 ((func == silver_pkg::fn_addc) ? {32'd0, carry_q} : 33'd0);
   assign diff = x - y;
   assign prod = {32'd0, x} * {32'd0, y};

   // signed overflow from operand and result signs
   assign add_ovf = (x[31] == y[31]) && (sum[31] != x[31]);
   assign sub_ovf = (x[31] != y[31]) && (diff[31] != x[31]);

   always_comb begin
      case (func)
         silver_pkg::fn_add,
         silver_pkg::fn_addc:     res = sum[31:0];
         silver_pkg::fn_sub:      res = diff;
         silver_pkg::fn_carry:    res = {31'd0, carry_q};
         silver_pkg::fn_overflow: res = {31'd0, ovf_q};
         silver_pkg::fn_inc:      res = x + 32'd1;
         silver_pkg::fn_dec:      res = x - 32'd1;
         silver_pkg::fn_mul:      res = prod[31:0];
         silver_pkg::fn_mulhu:    res = prod[63:32];
         silver_pkg::fn_and:      res = x & y;
         silver_pkg::fn_or:       res = x | y;
         silver_pkg::fn_xor:      res = x ^ y;
         silver_pkg::fn_equal:    res = {31'd0, x == y};
         silver_pkg::fn_less:     res = {31'd0, $signed(x) < $signed(y)};
         silver_pkg::fn_lower:    res = {31'd0, x < y};
         default:                 res = y; // snd
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         carry_q <= 1'b0;
         ovf_q   <= 1'b0;
      end else if (update) begin
         if (func == silver_pkg::fn_add || func == silver_pkg::fn_addc) begin
            carry_q <= sum[32];
            ovf_q   <= add_ovf;
         end else if (func == silver_pkg::fn_sub) begin
            ovf_q <= sub_ovf; // carry kept
         end
      end
   end

   a_flags_known: assert property (@(posedge clk) disable iff (!rst_n)
      !$isunknown({carry_q, ovf_q}));

endmodule

`default_nettype wire

// File: execute/silver_execute.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// branches resolve here; the core squashes the two younger stages
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module silver_execute (
   input  wire logic                 clk,
   input  wire logic                 rst_n,
   input  wire silver_pkg::id_ex_t   ex,
   input  wire silver_pkg::fwd_sel_t fwd_a,
   input  wire silver_pkg::fwd_sel_t fwd_b,
   input  wire silver_pkg::fwd_sel_t fwd_w,
   input  wire silver_pkg::ex_wb_t   mem,
   input  wire silver_pkg::ex_wb_t   wb,
   output silver_pkg::ex_wb_t        result,
   output logic                      branch_taken,
   output silver_pkg::word_t         branch_target
);

   silver_pkg::word_t a_v, b_v, w_v, alu_x, alu_y, alu_res, shift_res, const_res;
   logic [63:0] rot;
   logic is_jump, is_jz, is_jnz, alu_op;

   function automatic silver_pkg::word_t pick(input silver_pkg::fwd_sel_t sel,
                                              input silver_pkg::word_t base,
                                              input silver_pkg::word_t mem_res,
                                              input silver_pkg::word_t wb_res);
      case (sel)
         silver_pkg::fwd_mem: return mem_res;
         silver_pkg::fwd_wb:  return wb_res;
         default:             return base;
      endcase
   endfunction

   assign a_v = pick(fwd_a, ex.dec.a_imm ? ex.dec.imm_a : ex.a, mem.result, wb.result);
   assign b_v = pick(fwd_b, ex.dec.b_imm ? ex.dec.imm_b : ex.b, mem.result, wb.result);
   assign w_v = pick(fwd_w, ex.dec.w_imm ? ex.dec.imm_w : ex.w, mem.result, wb.result);

   assign is_jump = (ex.dec.opc == silver_pkg::opc_jump);
   assign is_jz   = (ex.dec.opc == silver_pkg::opc_jump_zero);
   assign is_jnz  = (ex.dec.opc == silver_pkg::opc_jump_not_zero);
   assign alu_op  = is_jump || is_jz || is_jnz || ex.dec.opc == silver_pkg::opc_normal ||
                    ex.dec.opc == silver_pkg::opc_out;

   assign alu_x = is_jump ? ex.pc : a_v;
   assign alu_y = is_jump ? a_v : b_v;

   silver_alu u_alu (
      .clk    (clk),
      .rst_n  (rst_n),
      .func   (ex.dec.func),
      .x      (alu_x),
      .y      (alu_y),
      .update (ex.valid && alu_op),
      .res    (alu_res)
   );

   always_comb begin
      rot = {a_v, a_v} >> b_v[4:0]; // ror by b mod 32
      case (ex.dec.func[1:0])
         2'd0:    shift_res = a_v << b_v;
         2'd1:    shift_res = a_v >> b_v;
         2'd2:    shift_res = $signed(a_v) >>> b_v;
         default: shift_res = rot[31:0];
      endcase
   end

   // upper constant keeps the low 23 bits of the old rd
   assign const_res = (ex.dec.opc == silver_pkg::opc_load_upper) ?
                      {ex.dec.const_val[31:23], w_v[22:0]} : ex.dec.const_val;

   always_comb begin
      result.valid  = ex.valid;
      result.rd     = ex.dec.rd;
      result.wr_reg = ex.dec.wr_reg;
      result.is_out = ex.dec.is_out;
      case (ex.dec.res_sel)
         silver_pkg::res_shift: result.result = shift_res;
         silver_pkg::res_link:  result.result = ex.pc + 32'd4;
         silver_pkg::res_const: result.result = const_res;
         default:               result.result = alu_res;
      endcase
   end

   assign branch_taken  = ex.valid && (is_jump || (is_jz && alu_res == 32'd0) ||
                                       (is_jnz && alu_res != 32'd0));
   assign branch_target = is_jump ? alu_res : ex.pc + w_v;

   a_branch_valid: assert property (@(posedge clk) disable iff (!rst_n)
      branch_taken |-> ex.valid && !$isunknown(branch_target));

endmodule

`default_nettype wire

// File: design/silver_core.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// inst_rdata must return the word at pc in the same cycle; never stalls
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module silver_core (
   input  wire logic              clk,
   input  wire logic              rst_n,
   output silver_pkg::word_t      pc,
   input  wire silver_pkg::word_t inst_rdata,
   output logic                   out_valid,
   output silver_pkg::word_t      out_data
);

   silver_pkg::word_t    id_instr;
   silver_pkg::word_t    id_pc;
   logic                 id_valid;
   silver_pkg::decoded_t id_dec;
   silver_pkg::word_t    rf_a, rf_b, rf_w;
   silver_pkg::id_ex_t   id_ex;
   silver_pkg::ex_wb_t   ex_res, ex_mem, mem_wb;
   silver_pkg::fwd_sel_t fwd_a, fwd_b, fwd_w;
   logic                 branch_taken;
   silver_pkg::word_t    branch_target;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         pc <= '0;
      else
         pc <= branch_taken ? branch_target : pc + 32'd4;
   end

   // decode register, fetch slot squashed by a taken branch
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         id_valid <= 1'b0;
      else
         id_valid <= !branch_taken;
   end

   always_ff @(posedge clk) begin
      id_instr <= inst_rdata;
      id_pc    <= pc;
   end

   silver_decoder u_decoder (
      .instr (id_instr),
      .dec   (id_dec)
   );

   silver_regfile u_regfile (
      .clk   (clk),
      .rst_n (rst_n),
      .ra    (id_dec.ra),
      .rb    (id_dec.rb),
      .rd    (id_dec.rd),
      .a     (rf_a),
      .b     (rf_b),
      .w     (rf_w),
      .wb    (mem_wb)
   );

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         id_ex <= '0;
      end else begin
         id_ex.valid <= id_valid && !branch_taken; // decode slot squash
         id_ex.pc    <= id_pc;
         id_ex.dec   <= id_dec;
         id_ex.a     <= rf_a;
         id_ex.b     <= rf_b;
         id_ex.w     <= rf_w;
      end
   end

   silver_forward u_forward (
      .ra    (id_ex.dec.ra),
      .rb    (id_ex.dec.rb),
      .rd    (id_ex.dec.rd),
      .a_imm (id_ex.dec.a_imm),
      .b_imm (id_ex.dec.b_imm),
      .w_imm (id_ex.dec.w_imm),
      .mem   (ex_mem),
      .wb    (mem_wb),
      .fwd_a (fwd_a),
      .fwd_b (fwd_b),
      .fwd_w (fwd_w)
   );

   silver_execute u_execute (
      .clk           (clk),
      .rst_n         (rst_n),
      .ex            (id_ex),
      .fwd_a         (fwd_a),
      .fwd_b         (fwd_b),
      .fwd_w         (fwd_w),
      .mem           (ex_mem),
      .wb            (mem_wb),
      .result        (ex_res),
      .branch_taken  (branch_taken),
      .branch_target (branch_target)
   );

   // memory stage only carries the result
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ex_mem <= '0;
         mem_wb <= '0;
      end else begin
         ex_mem <= ex_res;
         mem_wb <= ex_mem;
      end
   end

   assign out_valid = mem_wb.valid && mem_wb.is_out;
   assign out_data  = mem_wb.result;

endmodule

`default_nettype wire

// File: bench/silver_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// run from the project root; program and expected Outs come from the golden file
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module silver_tb;

   localparam int mem_words    = 256;
   localparam int max_outs     = 64;
   localparam int reset_cycles = 16;
   localparam int drain_cycles = 20;

   logic              clk;
   logic              rst_n;
   silver_pkg::word_t pc;
   silver_pkg::word_t inst_rdata;
   logic              out_valid;
   silver_pkg::word_t out_data;

   silver_pkg::word_t imem [mem_words];
   silver_pkg::word_t exp_val [max_outs];
   logic [8*24-1:0]   exp_name [max_outs]; // check name per expected Out
   int                n_prog;
   int                n_exp;
   int                out_idx;
   int                errors;
   logic              loaded;

   silver_core UUT (
      .clk        (clk),
      .rst_n      (rst_n),
      .pc         (pc),
      .inst_rdata (inst_rdata),
      .out_valid  (out_valid),
      .out_data   (out_data)
   );

   assign inst_rdata = imem[pc[9:2]]; // same-cycle fetch

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic load_golden();
      int                fd;
      int                code;
      int                i;
      logic [7:0]        marker;
      silver_pkg::word_t word;
      logic [8*24-1:0]   name;
      logic [8*128-1:0]  skip;
      logic              done;
      for (i = 0; i < mem_words; i++)
         imem[i] = (i << 6) | 15; // opcode 15 is a nop, upper bits follow the index
      fd = $fopen("bench/silver_golden.txt", "r");
      if (fd == 0) begin
         $display("cannot open bench/silver_golden.txt");
         errors++;
      end else begin
         done = 1'b0;
         while (!done) begin
            code = $fscanf(fd, " %c", marker);
            if (code != 1) begin
               done = 1'b1;
            end else if (marker == "#") begin
               code = $fgets(skip, fd);
            end else if (marker == "I" && n_prog < mem_words) begin
               code = $fscanf(fd, " %h", word);
               imem[n_prog] = word;
               n_prog++;
            end else if (marker == "O" && n_exp < max_outs) begin
               code = $fscanf(fd, " %h %s", word, name);
               exp_val[n_exp]  = word;
               exp_name[n_exp] = name;
               n_exp++;
            end else begin
               $display("golden file holds a line that cannot be read (marker %c)", marker);
               errors++;
               done = 1'b1;
            end
         end
         $fclose(fd);
      end
      if (n_prog == 0) begin
         $display("golden file holds no program words");
         errors++;
      end
   endtask

   task automatic report_counts();
      $display("outputs checked %0d of %0d, errors %0d", out_idx, n_exp, errors);
   endtask

   initial begin
      rst_n   = 1'b0;
      loaded  = 1'b0;
      n_prog  = 0;
      n_exp   = 0;
      out_idx = 0;
      errors  = 0;
      load_golden();
      loaded = 1'b1;
      repeat (reset_cycles) @(negedge clk);
      rst_n = 1'b1;
      while (out_idx < n_exp)
         @(posedge clk);
      repeat (drain_cycles) @(posedge clk); // any extra Out shows up here
      @(negedge clk);
      report_counts();
      if (errors == 0)
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   end

   // limit grows with the program, every word may cost up to four cycles
   initial begin
      wait (loaded);
      repeat (reset_cycles + n_prog * 4 + 100) @(posedge clk);
      $display("run timed out with expected outputs still missing");
      report_counts();
      $display("TESTS FAILED");
      $finish;
   end

   always @(posedge clk) begin
      if (!rst_n) begin
         assert (out_valid === 1'b0) else begin
            errors++;
            $display("out_valid went high during reset");
         end
         assert (pc === 32'd0) else begin
            errors++;
            $display("error reset_pc: expected %h actual %h", 32'd0, pc);
         end
      end else if (out_valid !== 1'b0) begin
         assert (out_idx < n_exp) else begin
            errors++;
            $display("unexpected Out with value %h after the last expected one", out_data);
         end
         if (out_idx < n_exp) begin
            assert (out_valid === 1'b1 && out_data === exp_val[out_idx]) else begin
               errors++;
               $display("error %0s: expected %h actual %h", exp_name[out_idx],
                        exp_val[out_idx], out_data);
            end
         end
         out_idx++;
      end
   end

endmodule

`default_nettype wire

// File: bench/silver_golden.txt
# I <hex>: program word, in address order from 0
# O <hex> <name>: expected Out value and check name, in output order
I 83800001
I 85000005
I 87000123
I 07000100
I 897FFFFF
I 090000FF
I 7E0013C6
O 7FFFFFFF upper_dist1
I 7E000FC6
O 80000123 upper_keep_low
I 7E080806
O 80000004 add
I 7E000106
O 00000001 overflow
I 7E020806
O 00000004 add_wrap
I 7E0000C6
O 00000001 carry
I 7E040846
O 0000000B addc
I 7E080486
O 80000000 sub
I 7E000106
O 00000001 sub_overflow
I 7E020146
O 00000000 inc
I 7E040186
O 00000004 dec
I 7E0609C6
O 800005AF mul
I 7E060A06
O 00000002 mulhu
I 7E061246
O 00000123 and
I 7E060A86
O 80000127 or
I 7E0806C6
O 80000000 xor
I 7E051706
O 00000001 equal
I 7E060B46
O 00000001 less
I 7E060B86
O 00000000 lower
I 7E020BC6
O 00000005 snd
I 0A071081
I 7E0017C6
O F8000012 sra
I 8F000024
I 0C061CC1
I 10050C01
I 0A037041
I 7E0017C6
O 0000000F srl
I 7E0023C6
O 00000028 sll
I 7E001BC6
O 38000012 ror
I 12040800
I 12122400
I 14040140
I 7E122806
O 0000001A dep_chain
I 90000BCA
I 7E0107C6
O 00000001 jz_not_taken
I 98000BCB
I 7E010BC6
I 7E010FC6
I 7E0113C6
O 00000004 jnz_taken
I 9004088A
I 7E0117C6
I 16980009
I 7E011BC6
I 7E011FC6
I 7E002FC6
O 000000C0 jump_link
I 00800009

// File: sim.f
common/silver_pkg.sv
design/silver_decoder.sv
design/silver_regfile.sv
design/silver_forward.sv
execute/silver_alu.sv
execute/silver_execute.sv
design/silver_core.sv
bench/silver_tb.sv

// File: Bender.yml
package:
  name: silver_core

sources:
  - files:
      - common/silver_pkg.sv
      - design/silver_decoder.sv
      - design/silver_regfile.sv
      - design/silver_forward.sv
      - execute/silver_alu.sv
      - execute/silver_execute.sv
      - design/silver_core.sv
  - target: test
    files:
      - bench/silver_tb.sv
